// ==== logic/sched_pkg.sv ====
// opcode enum, DRAM address, request id and core number types, default sizes
package sched_pkg;

    ////////////////////////////////////////////////////////////////////////
    // DRAM address split
    ////////////////////////////////////////////////////////////////////////
    localparam int bank_bits = 3;
    localparam int row_bits  = 14;
    localparam int col_bits  = 10;
    localparam int addr_bits = bank_bits + row_bits + col_bits;

    // frontend beat width and beats per backend word
    localparam int fe_width_dflt = 256;
    localparam int beats_dflt    = 4;

    ////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // bank in the top bits, then row, column at the bottom
    typedef logic [addr_bits-1:0] addr_t;

    // id handed back with read data
    typedef logic [4:0] req_id_t;

    // issuing core
    typedef logic [1:0] core_num_t;

endpackage

// ==== logic/sync_fifo.sv ====
// synchronous circular FIFO with full, empty and occupancy count
module sync_fifo #(
    parameter int data_width = 8,
    parameter int depth      = 4
) (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_push,
    input  logic [data_width-1:0]      i_data,
    input  logic                       i_pop,
    output logic [data_width-1:0]      o_data,
    output logic                       o_full,
    output logic                       o_empty,
    output logic [$clog2(depth+1)-1:0] o_count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [data_width-1:0] mem [depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    // push on full and pop on empty fall through
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_full  = (o_count == cnt_w'(depth));
    assign o_empty = (o_count == '0);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop)
            begin
                o_count <= o_count + 1'b1;
            end
            else if (!do_push && do_pop)
            begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

endmodule

// ==== logic/write_beat_packer.sv ====
// write beat collector, packs one request's beats into a backend word
module write_beat_packer import sched_pkg::*; #(
    parameter int fe_width = fe_width_dflt,
    parameter int beats    = beats_dflt
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  addr_t                     i_addr,
    input  logic                      i_wdata_valid,
    input  logic [fe_width-1:0]       i_wdata,
    input  logic                      i_wdata_last,
    output logic                      o_busy,
    output logic                      o_push,
    output addr_t                     o_addr,
    output logic [fe_width*beats-1:0] o_word
);

    localparam int be_width = fe_width * beats;

    typedef enum logic
    {
        PACK_IDLE,
        PACK_COLLECT
    } pack_e;

    pack_e state;
    logic  beat_in;
    logic  last_in;

    assign beat_in = (state == PACK_COLLECT) && i_wdata_valid;
    assign last_in = beat_in && i_wdata_last;

    // the push cycle counts as busy, the queue count is not updated yet
    assign o_busy = (state == PACK_COLLECT) || o_push;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state  <= PACK_IDLE;
            o_push <= 1'b0;
        end
        else
        begin
            o_push <= last_in;
            case (state)
                PACK_IDLE:
                begin
                    if (i_start)
                    begin
                        state <= PACK_COLLECT;
                    end
                end
                default:
                begin
                    if (last_in)
                    begin
                        state <= PACK_IDLE;
                    end
                end
            endcase
        end
    end

    // first beat ends up in the top slice
    always_ff @(posedge i_clk)
    begin
        if (i_start && (state == PACK_IDLE))
        begin
            o_addr <= i_addr;
        end
        if (beat_in)
        begin
            o_word <= (o_word << fe_width) | be_width'(i_wdata);
        end
    end

endmodule

// ==== logic/command_arbiter.sv ====
// read and write command queues, read-priority arbiter with write flush
module command_arbiter import sched_pkg::*; #(
    parameter int fe_width   = fe_width_dflt,
    parameter int beats      = beats_dflt,
    parameter int q_depth    = 4,
    parameter int flush_mark = 3
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_rd_push,
    input  addr_t                     i_rd_addr,
    input  req_id_t                   i_rd_id,
    input  core_num_t                 i_rd_core,
    input  logic                      i_wr_push,
    input  addr_t                     i_wr_addr,
    input  logic [fe_width*beats-1:0] i_wr_word,
    input  logic                      i_be_ready,
    output logic                      o_rd_full,
    output logic                      o_wr_full,
    output logic                      o_flush,
    output logic                      o_cmd_valid,
    output op_e                       o_cmd_op,
    output addr_t                     o_cmd_addr,
    output logic [fe_width*beats-1:0] o_cmd_wdata,
    output logic                      o_rd_issue,
    output req_id_t                   o_issue_id,
    output core_num_t                 o_issue_core
);

    localparam int be_width = fe_width * beats;
    localparam int rd_width = $bits(addr_t) + $bits(req_id_t) + $bits(core_num_t);
    localparam int wr_width = $bits(addr_t) + be_width;
    localparam int cnt_w    = $clog2(q_depth + 1);

    typedef enum logic
    {
        MODE_NORMAL,
        MODE_FLUSH
    } arb_mode_e;

    arb_mode_e             mode;
    logic [rd_width-1:0]   rd_head;
    logic [wr_width-1:0]   wr_head;
    addr_t                 rd_head_addr;
    addr_t                 wr_head_addr;
    logic [be_width-1:0]   wr_head_word;
    logic                  rd_empty;
    logic                  wr_empty;
    logic [cnt_w-1:0]      wr_count;
    logic                  pop_rd;
    logic                  pop_wr;

    ////////////////////////////////////////////////////////////////////////
    // queues
    ////////////////////////////////////////////////////////////////////////
    sync_fifo #(.data_width(rd_width), .depth(q_depth)) u_rd_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_rd_push),
        .i_data  ({i_rd_addr, i_rd_id, i_rd_core}),
        .i_pop   (pop_rd),
        .o_data  (rd_head),
        .o_full  (o_rd_full),
        .o_empty (rd_empty),
        .o_count ()
    );

    sync_fifo #(.data_width(wr_width), .depth(q_depth)) u_wr_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_wr_push),
        .i_data  ({i_wr_addr, i_wr_word}),
        .i_pop   (pop_wr),
        .o_data  (wr_head),
        .o_full  (o_wr_full),
        .o_empty (wr_empty),
        .o_count (wr_count)
    );

    assign {rd_head_addr, o_issue_id, o_issue_core} = rd_head;
    assign {wr_head_addr, wr_head_word} = wr_head;

    ////////////////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////////////////
    // reads first, writes only behind an empty read queue or in flush
    assign pop_rd = i_be_ready && !rd_empty && ((mode == MODE_NORMAL) || wr_empty);
    assign pop_wr = i_be_ready && !wr_empty && ((mode == MODE_FLUSH) || rd_empty);

    assign o_rd_issue = pop_rd;
    assign o_flush    = (mode == MODE_FLUSH);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            mode        <= MODE_NORMAL;
            o_cmd_valid <= 1'b0;
        end
        else
        begin
            o_cmd_valid <= pop_rd || pop_wr;
            case (mode)
                MODE_NORMAL:
                begin
                    if (wr_count >= cnt_w'(flush_mark))
                    begin
                        mode <= MODE_FLUSH;
                    end
                end
                default:
                begin
                    // a late packer push keeps the flush going
                    if (wr_empty && !i_wr_push)
                    begin
                        mode <= MODE_NORMAL;
                    end
                end
            endcase
        end
    end

    // command payload follows the popped entry
    always_ff @(posedge i_clk)
    begin
        if (pop_rd)
        begin
            o_cmd_op   <= OP_READ;
            o_cmd_addr <= rd_head_addr;
        end
        else if (pop_wr)
        begin
            o_cmd_op    <= OP_WRITE;
            o_cmd_addr  <= wr_head_addr;
            o_cmd_wdata <= wr_head_word;
        end
    end

endmodule

// ==== logic/read_beat_splitter.sv ====
// return word queue, read tag queue and beat-by-beat response output
module read_beat_splitter import sched_pkg::*; #(
    parameter int fe_width = fe_width_dflt,
    parameter int beats    = beats_dflt,
    parameter int q_depth  = 4
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_rd_issue,
    input  req_id_t                   i_issue_id,
    input  core_num_t                 i_issue_core,
    input  logic                      i_rdata_valid,
    input  logic [fe_width*beats-1:0] i_rdata,
    input  logic                      i_resp_ready,
    output logic                      o_rdata_ready,
    output logic                      o_resp_valid,
    output logic [fe_width-1:0]       o_resp_data,
    output logic                      o_resp_last,
    output req_id_t                   o_resp_id,
    output core_num_t                 o_resp_core
);

    localparam int be_width  = fe_width * beats;
    localparam int tag_width = $bits(req_id_t) + $bits(core_num_t);
    localparam int cnt_w     = $clog2(q_depth + 1);
    localparam int beat_w    = (beats > 1) ? $clog2(beats) : 1;
    // tags also cover reads still sitting inside the backend
    localparam int tag_depth = 8 * q_depth;

    logic [be_width-1:0]  ret_word;
    logic                 ret_empty;
    logic [cnt_w-1:0]     ret_count;
    logic [tag_width-1:0] tag_head;
    logic                 ret_push;
    logic                 beat_fire;
    logic                 word_done;
    logic [beat_w-1:0]    beat_cnt;
    logic [beat_w-1:0]    beat_sel;

    assign ret_push = i_rdata_valid && o_rdata_ready;

    sync_fifo #(.data_width(be_width), .depth(q_depth)) u_ret_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (ret_push),
        .i_data  (i_rdata),
        .i_pop   (word_done),
        .o_data  (ret_word),
        .o_full  (),
        .o_empty (ret_empty),
        .o_count (ret_count)
    );

    sync_fifo #(.data_width(tag_width), .depth(tag_depth)) u_tag_q (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (i_rd_issue),
        .i_data  ({i_issue_id, i_issue_core}),
        .i_pop   (word_done),
        .o_data  (tag_head),
        .o_full  (),
        .o_empty (),
        .o_count ()
    );

    ////////////////////////////////////////////////////////////////////////
    // response beats
    ////////////////////////////////////////////////////////////////////////
    // most significant slice goes out first
    assign beat_sel     = beat_w'(beats - 1) - beat_cnt;
    assign o_resp_valid = !ret_empty;
    assign o_resp_data  = ret_word[beat_sel * fe_width +: fe_width];
    assign o_resp_last  = o_resp_valid && (beat_cnt == beat_w'(beats - 1));
    assign {o_resp_id, o_resp_core} = tag_head;

    assign beat_fire = o_resp_valid && i_resp_ready;
    assign word_done = beat_fire && o_resp_last;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            beat_cnt      <= '0;
            o_rdata_ready <= 1'b0;
        end
        else
        begin
            // leaves room for one word that lands after ready drops
            o_rdata_ready <= (ret_count < cnt_w'(q_depth - 1));
            if (word_done)
            begin
                beat_cnt <= '0;
            end
            else if (beat_fire)
            begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/frontend_scheduler.sv ====
// DRAM frontend scheduler top, intake handshake and block wiring
module frontend_scheduler import sched_pkg::*; #(
    parameter int fe_width   = fe_width_dflt,
    parameter int beats      = beats_dflt,
    parameter int q_depth    = 4,
    parameter int flush_mark = 3
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    // intake from the interconnect
    input  logic                      i_req_valid,
    input  op_e                       i_req_op,
    input  addr_t                     i_req_addr,
    input  req_id_t                   i_req_id,
    input  core_num_t                 i_req_core,
    output logic                      o_req_ready,
    input  logic                      i_wdata_valid,
    input  logic [fe_width-1:0]       i_wdata,
    input  logic                      i_wdata_last,
    // commands to the backend
    output logic                      o_cmd_valid,
    output op_e                       o_cmd_op,
    output addr_t                     o_cmd_addr,
    output logic [fe_width*beats-1:0] o_cmd_wdata,
    input  logic                      i_be_ready,
    // read words back from the backend
    input  logic                      i_rdata_valid,
    input  logic [fe_width*beats-1:0] i_rdata,
    output logic                      o_rdata_ready,
    // read responses to the interconnect
    output logic                      o_resp_valid,
    output logic [fe_width-1:0]       o_resp_data,
    output logic                      o_resp_last,
    output req_id_t                   o_resp_id,
    output core_num_t                 o_resp_core,
    input  logic                      i_resp_ready
);

    localparam int be_width = fe_width * beats;

    logic                req_fire;
    logic                rd_push;
    logic                wr_start;
    logic                pack_busy;
    logic                wr_push;
    addr_t               wr_addr;
    logic [be_width-1:0] wr_word;
    logic                rd_full;
    logic                wr_full;
    logic                flush;
    logic                rd_issue;
    req_id_t             issue_id;
    core_num_t           issue_core;

    ////////////////////////////////////////////////////////////////////////
    // intake
    ////////////////////////////////////////////////////////////////////////
    assign o_req_ready = !rd_full && !wr_full && !pack_busy && !flush;
    assign req_fire    = i_req_valid && o_req_ready;
    assign rd_push     = req_fire && (i_req_op == OP_READ);
    assign wr_start    = req_fire && (i_req_op == OP_WRITE);

    write_beat_packer #(.fe_width(fe_width), .beats(beats)) u_packer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (wr_start),
        .i_addr        (i_req_addr),
        .i_wdata_valid (i_wdata_valid),
        .i_wdata       (i_wdata),
        .i_wdata_last  (i_wdata_last),
        .o_busy        (pack_busy),
        .o_push        (wr_push),
        .o_addr        (wr_addr),
        .o_word        (wr_word)
    );

    command_arbiter #(
        .fe_width   (fe_width),
        .beats      (beats),
        .q_depth    (q_depth),
        .flush_mark (flush_mark)
    ) u_arbiter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rd_push    (rd_push),
        .i_rd_addr    (i_req_addr),
        .i_rd_id      (i_req_id),
        .i_rd_core    (i_req_core),
        .i_wr_push    (wr_push),
        .i_wr_addr    (wr_addr),
        .i_wr_word    (wr_word),
        .i_be_ready   (i_be_ready),
        .o_rd_full    (rd_full),
        .o_wr_full    (wr_full),
        .o_flush      (flush),
        .o_cmd_valid  (o_cmd_valid),
        .o_cmd_op     (o_cmd_op),
        .o_cmd_addr   (o_cmd_addr),
        .o_cmd_wdata  (o_cmd_wdata),
        .o_rd_issue   (rd_issue),
        .o_issue_id   (issue_id),
        .o_issue_core (issue_core)
    );

    read_beat_splitter #(.fe_width(fe_width), .beats(beats), .q_depth(q_depth)) u_splitter (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rd_issue    (rd_issue),
        .i_issue_id    (issue_id),
        .i_issue_core  (issue_core),
        .i_rdata_valid (i_rdata_valid),
        .i_rdata       (i_rdata),
        .i_resp_ready  (i_resp_ready),
        .o_rdata_ready (o_rdata_ready),
        .o_resp_valid  (o_resp_valid),
        .o_resp_data   (o_resp_data),
        .o_resp_last   (o_resp_last),
        .o_resp_id     (o_resp_id),
        .o_resp_core   (o_resp_core)
    );

endmodule

// ==== verif/dram_model.sv ====
// behavioral DRAM backend, small memory, in-order read return with random delay
module dram_model import sched_pkg::*; #(
    parameter int be_width = 128
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_hold,
    input  logic                i_cmd_valid,
    input  op_e                 i_cmd_op,
    input  addr_t               i_cmd_addr,
    input  logic [be_width-1:0] i_cmd_wdata,
    output logic                o_be_ready,
    output logic                o_rdata_valid,
    output logic [be_width-1:0] o_rdata,
    input  logic                i_rdata_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [be_width-1:0] mem [16];
    logic [be_width-1:0] word_q [$];
    int                  due_q [$];
    int                  cycle;
    integer              seed;

    assign o_be_ready = !i_hold;

    // fill pattern carries the full index in every slice
    initial
    begin
        seed = 32'h3bad;
        cycle = 0;
        o_rdata_valid = 1'b0;
        o_rdata = '0;
        for (int i = 0; i < 16; i++)
        begin
            mem[i] = {(be_width / 32){32'ha5000000 ^ 32'(i)}};
        end
    end

    always @(posedge i_clk)
    begin
        cycle = cycle + 1;
        if (!i_rst_n)
        begin
            word_q.delete();
            due_q.delete();
        end
        else
        begin
            if (i_cmd_valid && (i_cmd_op == OP_WRITE))
            begin
                mem[i_cmd_addr[3:0]] = i_cmd_wdata;
            end
            else if (i_cmd_valid)
            begin
                word_q.push_back(mem[i_cmd_addr[3:0]]);
                due_q.push_back(cycle + 2 + int'($unsigned($random(seed)) % 4));
            end
            // word leaves once the scheduler takes it
            if (o_rdata_valid && i_rdata_ready)
            begin
                void'(word_q.pop_front());
                void'(due_q.pop_front());
            end
        end
        #2;
        o_rdata_valid = (word_q.size() > 0) && (cycle >= due_q[0]);
        o_rdata = (word_q.size() > 0) ? word_q[0] : '0;
    end

endmodule

// ==== verif/tb_frontend_scheduler.sv ====
// testbench for the DRAM frontend scheduler, stimulus, reference queue, assertions
module tb_frontend_scheduler import sched_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int fe_width    = 32;
    localparam int beats       = 4;
    localparam int be_width    = fe_width * beats;
    localparam int q_depth     = 4;
    localparam int flush_mark  = 3;
    localparam int cycle_limit = 4000;

    logic                i_clk;
    logic                i_rst_n;
    logic                i_req_valid;
    op_e                 i_req_op;
    addr_t               i_req_addr;
    req_id_t             i_req_id;
    core_num_t           i_req_core;
    logic                o_req_ready;
    logic                i_wdata_valid;
    logic [fe_width-1:0] i_wdata;
    logic                i_wdata_last;
    logic                o_cmd_valid;
    op_e                 o_cmd_op;
    addr_t               o_cmd_addr;
    logic [be_width-1:0] o_cmd_wdata;
    logic                i_be_ready;
    logic                i_rdata_valid;
    logic [be_width-1:0] i_rdata;
    logic                o_rdata_ready;
    logic                o_resp_valid;
    logic [fe_width-1:0] o_resp_data;
    logic                o_resp_last;
    req_id_t             o_resp_id;
    core_num_t           o_resp_core;
    logic                i_resp_ready;
    logic                hold;

    integer              seed;
    string               test_name;
    int                  cycles;
    int                  chk_mode;
    int                  cmds_seen;
    int                  writes_seen;
    int                  cmd_base;
    int                  wr_base;
    logic                rand_resp;
    req_id_t             next_id;
    logic [fe_width-1:0] ref_mem [16][beats];
    // {last, id, core, beat data}
    logic [39:0]         exp_q [$];
    logic [39:0]         exp_head;
    logic                exp_avail;

    frontend_scheduler #(
        .fe_width   (fe_width),
        .beats      (beats),
        .q_depth    (q_depth),
        .flush_mark (flush_mark)
    ) uut (.*);

    dram_model #(.be_width(be_width)) u_dram (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_hold        (hold),
        .i_cmd_valid   (o_cmd_valid),
        .i_cmd_op      (o_cmd_op),
        .i_cmd_addr    (o_cmd_addr),
        .i_cmd_wdata   (o_cmd_wdata),
        .o_be_ready    (i_be_ready),
        .o_rdata_valid (i_rdata_valid),
        .o_rdata       (i_rdata),
        .i_rdata_ready (o_rdata_ready)
    );

    always #20 i_clk = ~i_clk;

    //////////////////////////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////////////////////////
    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1);
        end
        if (o_cmd_valid)
        begin
            cmds_seen <= cmds_seen + 1;
            if (o_cmd_op == OP_WRITE)
            begin
                writes_seen <= writes_seen + 1;
            end
        end
        if (o_resp_valid && i_resp_ready && (exp_q.size() > 0))
        begin
            void'(exp_q.pop_front());
        end
        exp_avail <= (exp_q.size() > 0);
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    always @(posedge i_clk)
    begin
        #2;
        i_resp_ready = rand_resp ? $random(seed) % 2 != 0 : 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////////////////////////
    a_reset: assert property (@(posedge i_clk)
        (!i_rst_n || !$past(i_rst_n)) |-> !o_cmd_valid && !o_resp_valid && !o_resp_last)
    else
    begin
        $display("reset: command or response output active during reset");
        $display("** FAIL **");
        $fatal(1);
    end

    a_beat_expected: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_resp_valid && i_resp_ready) |-> exp_avail)
    else
    begin
        $display("%s: response beat arrived with no read outstanding", test_name);
        $display("** FAIL **");
        $fatal(1);
    end

    a_beat_value: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_resp_valid && i_resp_ready && exp_avail)
            |-> ({o_resp_last, o_resp_id, o_resp_core, o_resp_data} == exp_head))
    else
    begin
        $display("MISMATCH %s beat exp %h act %h", test_name, $sampled(exp_head),
            $sampled({o_resp_last, o_resp_id, o_resp_core, o_resp_data}));
        $display("** FAIL **");
        $fatal(1);
    end

    // stalled response must not move
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_resp_valid && !i_resp_ready) |=> (o_resp_valid && $stable(o_resp_data)
            && $stable(o_resp_last) && $stable(o_resp_id) && $stable(o_resp_core)))
    else
    begin
        $display("%s: response changed while stalled", test_name);
        $display("** FAIL **");
        $fatal(1);
    end

    a_read_first: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_cmd_valid && (chk_mode == 1) && (cmds_seen == cmd_base)) |-> o_cmd_op == OP_READ)
    else
    begin
        $display("MISMATCH %s cmd_op exp %0d act %0d", test_name, OP_READ, $sampled(o_cmd_op));
        $display("** FAIL **");
        $fatal(1);
    end

    a_flush_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_cmd_valid && (chk_mode == 2) && (o_cmd_op == OP_READ))
            |-> (writes_seen - wr_base) >= flush_mark)
    else
    begin
        $display("MISMATCH %s writes before read exp %0d act %0d", test_name, flush_mark,
            $sampled(writes_seen - wr_base));
        $display("** FAIL **");
        $fatal(1);
    end

    // intake stays closed until every flushed write has gone out
    a_flush_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        ((chk_mode == 2) && ((writes_seen - wr_base) < flush_mark)) |-> !o_req_ready)
    else
    begin
        $display("%s: request ready high during write flush", test_name);
        $display("** FAIL **");
        $fatal(1);
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////
    function automatic addr_t make_addr(input logic [3:0] idx);
        addr_t a;
        a = addr_t'($random(seed));
        a[3:0] = idx;
        return a;
    endfunction

    task automatic send_req(input op_e op, input addr_t addr, input req_id_t id,
                            input core_num_t core);
        @(posedge i_clk);
        #2;
        i_req_valid = 1'b1;
        i_req_op = op;
        i_req_addr = addr;
        i_req_id = id;
        i_req_core = core;
        @(negedge i_clk);
        while (!o_req_ready)
        begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #2;
        i_req_valid = 1'b0;
    endtask

    task automatic write_word(input logic [3:0] idx);
        logic [fe_width-1:0] beat;
        send_req(OP_WRITE, make_addr(idx), '0, '0);
        for (int b = 0; b < beats; b++)
        begin
            beat = $random(seed);
            ref_mem[idx][b] = beat;
            i_wdata_valid = 1'b1;
            i_wdata = beat;
            i_wdata_last = (b == beats - 1);
            @(posedge i_clk);
            #2;
            i_wdata_valid = 1'b0;
            i_wdata_last = 1'b0;
        end
    endtask

    task automatic read_word(input logic [3:0] idx);
        core_num_t core;
        core = core_num_t'($random(seed));
        for (int b = 0; b < beats; b++)
        begin
            exp_q.push_back({(b == beats - 1), next_id, core, ref_mem[idx][b]});
        end
        send_req(OP_READ, make_addr(idx), next_id, core);
        next_id = next_id + 1'b1;
    endtask

    task automatic drain_responses();
        while (exp_q.size() != 0)
        begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        seed = 32'h3bad;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_req_valid = 1'b0;
        i_req_op = OP_READ;
        i_req_addr = '0;
        i_req_id = '0;
        i_req_core = '0;
        i_wdata_valid = 1'b0;
        i_wdata = '0;
        i_wdata_last = 1'b0;
        i_resp_ready = 1'b1;
        hold = 1'b0;
        rand_resp = 1'b0;
        next_id = '0;
        cycles = 0;
        chk_mode = 0;
        cmds_seen = 0;
        writes_seen = 0;
        cmd_base = 0;
        wr_base = 0;
        test_name = "reset";
        for (int i = 0; i < 16; i++)
        begin
            for (int b = 0; b < beats; b++)
            begin
                ref_mem[i][b] = 32'ha5000000 ^ 32'(i);
            end
        end
        repeat (8) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;

        test_name = "write_read";
        write_word(4'd0);
        read_word(4'd0);
        drain_responses();

        // low indices for reads, high for stream writes, so no read passes a write
        test_name = "read_priority";
        #2;
        hold = 1'b1;
        write_word(4'd1);
        read_word(4'd2);
        repeat (3) @(posedge i_clk);
        cmd_base = cmds_seen;
        chk_mode = 1;
        #2;
        hold = 1'b0;
        drain_responses();

        test_name = "write_flush";
        chk_mode = 0;
        #2;
        hold = 1'b1;
        read_word(4'd3);
        for (int i = 0; i < flush_mark; i++)
        begin
            write_word(4'(4 + i));
        end
        repeat (3) @(posedge i_clk);
        wr_base = writes_seen;
        chk_mode = 2;
        #2;
        hold = 1'b0;
        drain_responses();
        chk_mode = 0;

        test_name = "backpressure";
        rand_resp = 1'b1;
        for (int n = 0; n < 20; n++)
        begin
            if ($random(seed) % 2 != 0)
            begin
                write_word(4'(8 + ($unsigned($random(seed)) % 8)));
            end
            else
            begin
                read_word(4'($unsigned($random(seed)) % 8));
            end
        end
        drain_responses();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== frontend_scheduler.f ====
logic/sched_pkg.sv
logic/sync_fifo.sv
logic/write_beat_packer.sv
logic/command_arbiter.sv
logic/read_beat_splitter.sv
logic/frontend_scheduler.sv
verif/dram_model.sv
verif/tb_frontend_scheduler.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_frontend_scheduler \
    -f frontend_scheduler.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log
